// ==== project.f ====
+incdir+verif
source/rename_pkg.sv
source/free_list.sv
source/map_table.sv
source/arch_map.sv
source/reorder_buffer.sv
source/rename_commit_top.sv
verif/tb_rename_commit.sv

// ==== source/arch_map.sv ====
// ####################
// committed rename map
// ####################
module arch_map import rename_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      commit_i,      // head retires this cycle
	input  logic [LOG_W-1:0]          commit_dest_i,
	input  logic [TAG_W-1:0]          commit_tag_i,
	output logic [LOG_REGS*TAG_W-1:0] arch_map_o,    // stored map
	output logic [LOG_REGS*TAG_W-1:0] fwd_map_o      // stored map plus this commit
);

	logic [TAG_W-1:0] map_r [LOG_REGS];
	logic             commit_en;

	assign commit_en = commit_i && (commit_dest_i != ZERO_REG);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < LOG_REGS; r++) begin
				map_r[r] <= TAG_W'(r);
			end
		end else if (commit_en) begin
			map_r[commit_dest_i] <= commit_tag_i;
		end
	end

	// forwarded view lets a retiring branch restore its own write
	always_comb begin
		for (int r = 0; r < LOG_REGS; r++) begin
			arch_map_o[r*TAG_W +: TAG_W] = map_r[r];
			if (commit_en && (commit_dest_i == LOG_W'(r))) begin
				fwd_map_o[r*TAG_W +: TAG_W] = commit_tag_i;
			end else begin
				fwd_map_o[r*TAG_W +: TAG_W] = map_r[r];
			end
		end
	end

endmodule

// ==== source/free_list.sv ====
// ####################
// circular FIFO of free physical tags
// ####################
module free_list import rename_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             alloc_i,   // take the tag at the read pointer
	input  logic             rel_i,     // return a tag at retirement
	input  logic [TAG_W-1:0] rel_tag_i,
	input  logic             flush_i,   // give back all speculative tags
	output logic [TAG_W-1:0] new_tag_o
);

	logic [TAG_W-1:0]      slots_r [FREE_DEPTH];
	logic [FREE_IDX_W-1:0] rd_ptr_r;
	logic [FREE_IDX_W-1:0] wr_ptr_r;
	logic [FREE_IDX_W-1:0] wr_ptr_nxt;
	logic                  rel_en;

	assign new_tag_o = slots_r[rd_ptr_r];

	// tag 0 belongs to r0 and never circulates
	assign rel_en = rel_i && (rel_tag_i != '0);

	assign wr_ptr_nxt = rel_en ? wr_ptr_r + FREE_IDX_W'(1) : wr_ptr_r;

	// slots start out as the tags above the identity map
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < FREE_DEPTH; i++) begin
				slots_r[i] <= TAG_W'(FREE_BASE_TAG + i);
			end
		end else if (rel_en) begin
			slots_r[wr_ptr_r] <= rel_tag_i;
		end
	end

	// Pointers wrap naturally over the FREE_DEPTH slots. Equal pointers mean
	// full except while every entry of the ROB holds a tag, and no
	// allocation can happen then.
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr_r <= '0;
			wr_ptr_r <= '0;
		end else begin
			wr_ptr_r <= wr_ptr_nxt;
			if (flush_i) begin
				// squashed tags are still in the slots behind the read pointer
				rd_ptr_r <= wr_ptr_nxt;
			end else if (alloc_i) begin
				rd_ptr_r <= rd_ptr_r + FREE_IDX_W'(1);
			end
		end
	end

	// After a flush the free list holds every tag outside the committed
	// map. The younger instructions took the most recent reads, and those
	// slots lie between the new write pointer and the old read pointer,
	// so no release has overwritten them yet.

endmodule

// ==== source/map_table.sv ====
// ####################
// speculative rename map
// ####################
module map_table import rename_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rename_i,      // dispatch with a real destination
	input  logic [LOG_W-1:0]          rename_dest_i,
	input  logic [TAG_W-1:0]          rename_tag_i,
	input  logic [LOG_W-1:0]          lookup_dest_i,
	output logic [TAG_W-1:0]          old_tag_o,     // mapping being replaced
	input  logic                      restore_i,     // mispredict recovery
	input  logic [LOG_REGS*TAG_W-1:0] restore_map_i  // committed map, r0 in low bits
);

	logic [TAG_W-1:0] map_r [LOG_REGS];
	logic             rename_en;

	// lookup sees the map before this cycle's rename
	assign old_tag_o = map_r[lookup_dest_i];

	assign rename_en = rename_i && (rename_dest_i != ZERO_REG);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < LOG_REGS; r++) begin
				map_r[r] <= TAG_W'(r); // identity map
			end
		end else if (restore_i) begin
			// throw away every speculative mapping in one cycle
			for (int r = 0; r < LOG_REGS; r++) begin
				map_r[r] <= restore_map_i[r*TAG_W +: TAG_W];
			end
		end else if (rename_en) begin
			map_r[rename_dest_i] <= rename_tag_i;
		end
	end

	// Restore and rename never meet, since dispatch is held off while a
	// flush is raised. Restore still takes priority so that a stray rename
	// can not leak into the recovered map.

endmodule

// ==== source/rename_commit_top.sv ====
// ####################
// rename and commit slice around the reorder buffer
// ####################
module rename_commit_top import rename_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,

	// dispatch, valid/ready
	input  logic                 disp_valid_i,
	output logic                 disp_ready_o,
	input  logic [LOG_W-1:0]     disp_logic_dest_i,
	input  logic [PC_W-1:0]      disp_pc_i,
	input  logic                 disp_br_i,
	input  logic                 disp_pred_taken_i,
	output logic [ROB_IDX_W-1:0] disp_rob_idx_o,
	output logic [TAG_W-1:0]     disp_phys_dest_o,

	// completion strobe
	input  logic                 cmpl_valid_i,
	input  logic [ROB_IDX_W-1:0] cmpl_rob_idx_i,
	input  logic                 cmpl_taken_i,

	// retirement
	output logic                 ret_valid_o,
	output logic [LOG_W-1:0]     ret_logic_dest_o,
	output logic [TAG_W-1:0]     ret_phys_dest_o,
	output logic [TAG_W-1:0]     ret_free_tag_o,
	output logic [PC_W-1:0]      ret_pc_o,
	output logic                 flush_o
);

	logic                      alloc_fire;
	logic [TAG_W-1:0]          new_tag;
	logic [TAG_W-1:0]          old_tag;
	logic                      retire_fire;
	logic [LOG_W-1:0]          retire_logic_dest;
	logic [TAG_W-1:0]          retire_phys_dest;
	logic [TAG_W-1:0]          retire_free_tag;
	logic                      flush;
	logic [LOG_REGS*TAG_W-1:0] arch_map_flat;

	// r0 shows tag 0 and the ROB records the same
	assign disp_phys_dest_o = (disp_logic_dest_i == ZERO_REG) ? '0 : new_tag;

	assign ret_valid_o = retire_fire;
	assign ret_logic_dest_o = retire_logic_dest;
	assign ret_phys_dest_o = retire_phys_dest;
	assign ret_free_tag_o = retire_free_tag;
	assign flush_o = flush;

	free_list u_free_list (
		.clk       (clk),
		.rst       (rst),
		.alloc_i   (alloc_fire),
		.rel_i     (retire_fire),
		.rel_tag_i (retire_free_tag),
		.flush_i   (flush),
		.new_tag_o (new_tag)
	);

	map_table u_map_table (
		.clk           (clk),
		.rst           (rst),
		.rename_i      (alloc_fire),
		.rename_dest_i (disp_logic_dest_i),
		.rename_tag_i  (new_tag),
		.lookup_dest_i (disp_logic_dest_i),
		.old_tag_o     (old_tag),
		.restore_i     (flush),
		.restore_map_i (arch_map_flat)
	);

	// restore uses the forwarded map so the branch's own write survives
	arch_map u_arch_map (
		.clk           (clk),
		.rst           (rst),
		.commit_i      (retire_fire),
		.commit_dest_i (retire_logic_dest),
		.commit_tag_i  (retire_phys_dest),
		.arch_map_o    (),
		.fwd_map_o     (arch_map_flat)
	);

	reorder_buffer u_rob (
		.clk               (clk),
		.rst               (rst),
		.disp_valid_i      (disp_valid_i),
		.disp_logic_dest_i (disp_logic_dest_i),
		.disp_pc_i         (disp_pc_i),
		.disp_br_i         (disp_br_i),
		.disp_pred_taken_i (disp_pred_taken_i),
		.new_tag_i         (new_tag),
		.old_tag_i         (old_tag),
		.cmpl_valid_i      (cmpl_valid_i),
		.cmpl_rob_idx_i    (cmpl_rob_idx_i),
		.cmpl_taken_i      (cmpl_taken_i),
		.disp_ready_o      (disp_ready_o),
		.alloc_o           (alloc_fire),
		.tail_idx_o        (disp_rob_idx_o),
		.ret_valid_o       (retire_fire),
		.ret_logic_dest_o  (retire_logic_dest),
		.ret_phys_dest_o   (retire_phys_dest),
		.ret_free_tag_o    (retire_free_tag),
		.ret_pc_o          (ret_pc_o),
		.flush_o           (flush)
	);

endmodule

// ==== source/rename_pkg.sv ====
// ####################
// widths, depths and reset constants for rename and commit
// ####################
package rename_pkg;

	// architectural register file
	localparam int LOG_REGS = 32;
	localparam int LOG_W = 5; // logical register index

	// physical register file
	localparam int PHYS_REGS = 64;
	localparam int TAG_W = 6; // physical tag

	// reorder buffer
	localparam int ROB_DEPTH = 32;
	localparam int ROB_IDX_W = 5;
	localparam int PTR_W = 6; // index plus wrap bit

	// free list holds every tag not in the committed map
	localparam int FREE_DEPTH = PHYS_REGS - LOG_REGS;
	localparam int FREE_IDX_W = 5;

	localparam int PC_W = 64;

	// r0 is hardwired and never renamed
	localparam logic [LOG_W-1:0] ZERO_REG = '0;

	// after reset the free list holds tags LOG_REGS and up
	localparam int FREE_BASE_TAG = LOG_REGS;

endpackage

// ==== source/reorder_buffer.sv ====
// ####################
// reorder buffer, in-order allocate and retire, out-of-order completion
// ####################
module reorder_buffer import rename_pkg::*; (
	input  logic                 clk,
	input  logic                 rst,

	// dispatch
	input  logic                 disp_valid_i,
	input  logic [LOG_W-1:0]     disp_logic_dest_i,
	input  logic [PC_W-1:0]      disp_pc_i,
	input  logic                 disp_br_i,
	input  logic                 disp_pred_taken_i,
	input  logic [TAG_W-1:0]     new_tag_i,         // from free list
	input  logic [TAG_W-1:0]     old_tag_i,         // from map table

	// completion
	input  logic                 cmpl_valid_i,
	input  logic [ROB_IDX_W-1:0] cmpl_rob_idx_i,
	input  logic                 cmpl_taken_i,      // resolved direction

	output logic                 disp_ready_o,
	output logic                 alloc_o,           // dispatch that consumes a tag
	output logic [ROB_IDX_W-1:0] tail_idx_o,

	// retirement
	output logic                 ret_valid_o,
	output logic [LOG_W-1:0]     ret_logic_dest_o,
	output logic [TAG_W-1:0]     ret_phys_dest_o,
	output logic [TAG_W-1:0]     ret_free_tag_o,
	output logic [PC_W-1:0]      ret_pc_o,
	output logic                 flush_o
);

	logic [PTR_W-1:0]     head_r;
	logic [PTR_W-1:0]     tail_r;
	logic [ROB_IDX_W-1:0] head_idx;
	logic [ROB_IDX_W-1:0] tail_idx;

	// entry payload
	logic [LOG_W-1:0]     dest_r [ROB_DEPTH];
	logic [TAG_W-1:0]     phys_r [ROB_DEPTH];
	logic [TAG_W-1:0]     old_r [ROB_DEPTH];
	logic [PC_W-1:0]      pc_r [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] br_r;
	logic [ROB_DEPTH-1:0] pred_r;
	logic [ROB_DEPTH-1:0] mispred_r;

	// entry state
	logic [ROB_DEPTH-1:0] done_r;

	logic                 full;
	logic                 disp_fire;
	logic                 dest_zero;

	assign head_idx = head_r[ROB_IDX_W-1:0];
	assign tail_idx = tail_r[ROB_IDX_W-1:0];
	assign tail_idx_o = tail_idx;

	// same slot, opposite lap
	assign full = (head_idx == tail_idx) && (head_r[PTR_W-1] != tail_r[PTR_W-1]);

	assign disp_ready_o = !full && !flush_o;
	assign disp_fire = disp_valid_i && disp_ready_o;
	assign dest_zero = (disp_logic_dest_i == ZERO_REG);
	assign alloc_o = disp_fire && !dest_zero; // r0 takes no tag

	// head leaves as soon as it is done
	assign ret_valid_o = done_r[head_idx];
	assign ret_logic_dest_o = dest_r[head_idx];
	assign ret_phys_dest_o = phys_r[head_idx];
	assign ret_free_tag_o = old_r[head_idx];
	assign ret_pc_o = pc_r[head_idx];
	assign flush_o = ret_valid_o && mispred_r[head_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			head_r <= '0;
			tail_r <= '0;
			done_r <= '0;
		end else begin
			if (ret_valid_o) begin
				head_r <= head_r + PTR_W'(1);
			end

			if (flush_o) begin
				// everything younger than the branch is gone
				tail_r <= head_r + PTR_W'(1);
				done_r <= '0;
			end else begin
				if (disp_fire) begin
					tail_r <= tail_r + PTR_W'(1);
					done_r[tail_idx] <= 1'b0;
				end
				if (cmpl_valid_i) begin
					done_r[cmpl_rob_idx_i] <= 1'b1;
				end
				if (ret_valid_o) begin
					done_r[head_idx] <= 1'b0;
				end
			end
		end
	end

	// A completion in the flush cycle can only name a squashed entry, so
	// it is dropped together with the rest of the younger work.

	always_ff @(posedge clk) begin
		if (disp_fire) begin
			dest_r[tail_idx] <= disp_logic_dest_i;
			phys_r[tail_idx] <= dest_zero ? '0 : new_tag_i; // r0 keeps tag 0
			old_r[tail_idx]  <= old_tag_i;
			pc_r[tail_idx]   <= disp_pc_i;
			br_r[tail_idx]   <= disp_br_i;
			pred_r[tail_idx] <= disp_pred_taken_i;
		end
		if (cmpl_valid_i) begin
			// only branches can mispredict
			mispred_r[cmpl_rob_idx_i] <= br_r[cmpl_rob_idx_i] &&
				(cmpl_taken_i != pred_r[cmpl_rob_idx_i]);
		end
	end

endmodule

// ==== verif/rename_model.svh ====
// ####################
// reference model of free list, rename maps and in-order ROB queue
// ####################
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

typedef struct {
	logic [LOG_W-1:0]     dest;
	logic [TAG_W-1:0]     tag;
	logic [TAG_W-1:0]     old;
	logic [PC_W-1:0]      pc;
	logic                 br;
	logic                 pred;
	logic                 done;
	logic                 misp;
	logic [ROB_IDX_W-1:0] idx;
} rob_entry_t;

logic [TAG_W-1:0]     m_slots [FREE_DEPTH];
int                   m_rd;
int                   m_wr;
logic [TAG_W-1:0]     m_spec [LOG_REGS];
logic [TAG_W-1:0]     m_arch [LOG_REGS];
logic [ROB_IDX_W-1:0] m_tail;
rob_entry_t           m_q [$];

function automatic void model_reset();
	for (int i = 0; i < FREE_DEPTH; i++) m_slots[i] = TAG_W'(LOG_REGS + i);
	for (int r = 0; r < LOG_REGS; r++) begin
		m_spec[r] = TAG_W'(r); // identity
		m_arch[r] = TAG_W'(r);
	end
	m_rd = 0;
	m_wr = 0;
	m_tail = '0;
	m_q.delete();
endfunction

// predicts the ROB slot and new tag of one dispatch
function automatic void model_dispatch(input logic [LOG_W-1:0] dest, input logic [PC_W-1:0] pc,
		input logic br, input logic pred, output logic [ROB_IDX_W-1:0] idx,
		output logic [TAG_W-1:0] tag);
	rob_entry_t e;
	e.dest = dest;
	e.old = m_spec[dest];
	e.tag = '0; // r0 keeps tag 0
	if (dest != '0) begin
		e.tag = m_slots[m_rd];
		m_rd = (m_rd + 1) % FREE_DEPTH;
		m_spec[dest] = e.tag;
	end
	e.pc = pc;
	e.br = br;
	e.pred = pred;
	e.done = 1'b0;
	e.misp = 1'b0;
	e.idx = m_tail;
	m_tail = m_tail + 1'b1;
	m_q.push_back(e);
	idx = e.idx;
	tag = e.tag;
endfunction

function automatic void model_complete(input logic [ROB_IDX_W-1:0] idx, input logic taken);
	foreach (m_q[i]) begin
		if (m_q[i].idx == idx) begin
			m_q[i].done = 1'b1;
			m_q[i].misp = m_q[i].br && (taken != m_q[i].pred);
		end
	end
endfunction

// pops the head and applies commit, release and mispredict recovery
function automatic rob_entry_t model_retire();
	rob_entry_t e;
	e = m_q.pop_front();
	if (e.dest != '0) m_arch[e.dest] = e.tag;
	if (e.old != '0) begin
		m_slots[m_wr] = e.old;
		m_wr = (m_wr + 1) % FREE_DEPTH;
	end
	if (e.misp) begin
		m_q.delete();
		for (int r = 0; r < LOG_REGS; r++) m_spec[r] = m_arch[r];
		m_rd = m_wr; // every speculative tag is free again
		m_tail = e.idx + 1'b1;
	end
	return e;
endfunction

`endif

// ==== verif/tb_rename_commit.sv ====
// ####################
// testbench for the rename and commit slice with directed and random tests
// ####################
module tb_rename_commit import rename_pkg::*; ();

	logic                 clk;
	logic                 rst;
	logic                 disp_valid_i;
	logic                 disp_ready_o;
	logic [LOG_W-1:0]     disp_logic_dest_i;
	logic [PC_W-1:0]      disp_pc_i;
	logic                 disp_br_i;
	logic                 disp_pred_taken_i;
	logic [ROB_IDX_W-1:0] disp_rob_idx_o;
	logic [TAG_W-1:0]     disp_phys_dest_o;
	logic                 cmpl_valid_i;
	logic [ROB_IDX_W-1:0] cmpl_rob_idx_i;
	logic                 cmpl_taken_i;
	logic                 ret_valid_o;
	logic [LOG_W-1:0]     ret_logic_dest_o;
	logic [TAG_W-1:0]     ret_phys_dest_o;
	logic [TAG_W-1:0]     ret_free_tag_o;
	logic [PC_W-1:0]      ret_pc_o;
	logic                 flush_o;

	`include "rename_model.svh"

	int                   errors = 0;
	int                   checks = 0;
	int                   cycles = 0;
	int                   flush_seen = 0;
	logic [PC_W-1:0]      pc_next = 64'h1000;
	logic [ROB_IDX_W-1:0] last_idx;
	logic [TAG_W-1:0]     last_tag;
	logic [TAG_W-1:0]     last_free;

	rename_commit_top DUT (.*);

	always #5 clk = ~clk;

	// the six tests take well under 1000 cycles together
	always @(posedge clk) begin
		cycles++;
		if (cycles >= 4000) begin
			$display("timeout after %0d cycles, ROB never drained", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("error at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// retire outputs still hold their pre-edge values here
	always @(posedge clk) begin
		rob_entry_t e;
		if (!rst && ret_valid_o) begin
			last_free = ret_free_tag_o;
			if (flush_o) flush_seen++;
			if (m_q.size() == 0) begin
				$display("retire at %0t while no instruction is pending", $time);
				errors++;
			end else begin
				if (!m_q[0].done) begin
					$display("retire at %0t of an instruction never completed", $time);
					errors++;
				end
				e = model_retire();
				check_val("ret_logic_dest_o", ret_logic_dest_o, e.dest);
				check_val("ret_phys_dest_o", ret_phys_dest_o, e.tag);
				check_val("ret_free_tag_o", ret_free_tag_o, e.old);
				check_val("ret_pc_o", ret_pc_o, e.pc);
				check_val("flush_o", flush_o, e.misp);
			end
		end
	end

	// one cycle, entered and left 1 unit after the rising edge
	task automatic run_cycle(input logic dv, input logic [LOG_W-1:0] dest, input logic br,
			input logic pred, input logic cv, input logic [ROB_IDX_W-1:0] cidx,
			input logic ctaken, output logic fired);
		logic [ROB_IDX_W-1:0] exp_idx;
		logic [TAG_W-1:0]     exp_tag;
		disp_valid_i = dv;
		disp_logic_dest_i = dest;
		disp_pc_i = pc_next;
		disp_br_i = br;
		disp_pred_taken_i = pred;
		cmpl_valid_i = cv;
		cmpl_rob_idx_i = cidx;
		cmpl_taken_i = ctaken;
		if (cv) model_complete(cidx, ctaken);
		#3;
		fired = dv && disp_ready_o;
		if (fired) begin
			model_dispatch(dest, pc_next, br, pred, exp_idx, exp_tag);
			check_val("disp_rob_idx_o", disp_rob_idx_o, exp_idx);
			check_val("disp_phys_dest_o", disp_phys_dest_o, exp_tag);
			last_idx = exp_idx;
			last_tag = disp_phys_dest_o;
			pc_next = pc_next + 4;
		end
		@(posedge clk);
		#1;
		disp_valid_i = 1'b0;
		cmpl_valid_i = 1'b0;
	endtask

	task automatic dispatch(input logic [LOG_W-1:0] dest, input logic br, input logic pred);
		logic fired;
		fired = 1'b0;
		while (!fired) run_cycle(1'b1, dest, br, pred, 1'b0, '0, 1'b0, fired);
	endtask

	task automatic complete(input logic [ROB_IDX_W-1:0] idx, input logic taken);
		logic fired;
		run_cycle(1'b0, '0, 1'b0, 1'b0, 1'b1, idx, taken, fired);
	endtask

	// completes what is left, oldest first, until the model queue is empty
	task automatic drain_rob();
		logic fired;
		int   k;
		while (m_q.size() > 0) begin
			k = -1;
			foreach (m_q[i]) if (k < 0 && !m_q[i].done) k = i;
			if (k >= 0) run_cycle(1'b0, '0, 1'b0, 1'b0, 1'b1, m_q[k].idx, m_q[k].pred, fired);
			else run_cycle(1'b0, '0, 1'b0, 1'b0, 1'b0, '0, 1'b0, fired);
		end
	endtask

	task automatic report(input int num, input string name, input int start_errs);
		$display("test %0d %s: %s", num, name, (errors == start_errs) ? "ok" : "wrong");
	endtask

	initial begin
		int                   e0;
		int                   f0;
		int                   k;
		logic                 fired;
		logic [ROB_IDX_W-1:0] idxs [$];
		int                   open [$];
		void'($urandom(32'h4002));
		clk = 1'b0;
		rst = 1'b1;
		disp_valid_i = 1'b0;
		disp_logic_dest_i = '0;
		disp_pc_i = '0;
		disp_br_i = 1'b0;
		disp_pred_taken_i = 1'b0;
		cmpl_valid_i = 1'b0;
		cmpl_rob_idx_i = '0;
		cmpl_taken_i = 1'b0;
		model_reset();
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		e0 = errors;
		check_val("disp_ready_o", disp_ready_o, 1'b1);
		check_val("ret_valid_o", ret_valid_o, 1'b0);
		for (int i = 0; i < 3; i++) begin
			dispatch(LOG_W'(i + 1), 1'b0, 1'b0);
			check_val("disp_phys_dest_o", last_tag, 32 + i);
		end
		drain_rob();
		report(1, "reset and first tags", e0);

		e0 = errors;
		idxs.delete();
		dispatch(5'd5, 1'b0, 1'b0);
		idxs.push_back(last_idx);
		dispatch(5'd6, 1'b0, 1'b0);
		idxs.push_back(last_idx);
		dispatch(5'd5, 1'b0, 1'b0);
		idxs.push_back(last_idx);
		dispatch(5'd7, 1'b0, 1'b0);
		idxs.push_back(last_idx);
		dispatch(5'd8, 1'b0, 1'b0);
		idxs.push_back(last_idx);
		for (int i = 4; i >= 0; i--) complete(idxs[i], 1'b0);
		drain_rob();
		report(2, "reverse completion", e0);

		e0 = errors;
		for (int i = 0; i < ROB_DEPTH; i++) dispatch(LOG_W'(i % 31 + 1), 1'b0, 1'b0);
		check_val("disp_ready_o", disp_ready_o, 1'b0);
		run_cycle(1'b1, 5'd3, 1'b0, 1'b0, 1'b0, '0, 1'b0, fired);
		if (fired) begin
			$display("dispatch accepted at %0t while the ROB was full", $time);
			errors++;
		end
		drain_rob();
		check_val("disp_ready_o", disp_ready_o, 1'b1);
		report(3, "full ROB", e0);

		e0 = errors;
		f0 = flush_seen;
		idxs.delete();
		dispatch(5'd9, 1'b1, 1'b1);
		idxs.push_back(last_idx);
		for (int i = 10; i < 13; i++) begin
			dispatch(LOG_W'(i), 1'b0, 1'b0);
			idxs.push_back(last_idx);
		end
		for (int i = 3; i > 0; i--) complete(idxs[i], 1'b0);
		complete(idxs[0], 1'b0); // resolved not taken
		drain_rob();
		if (flush_seen != f0 + 1) begin
			$display("mispredicted branch retired without a flush");
			errors++;
		end
		for (int i = 0; i < 3; i++) dispatch(LOG_W'(20 + i), 1'b0, 1'b0);
		drain_rob();
		report(4, "branch mispredict", e0);

		e0 = errors;
		dispatch(ZERO_REG, 1'b0, 1'b0);
		check_val("disp_phys_dest_o", last_tag, 0);
		dispatch(ZERO_REG, 1'b0, 1'b0);
		drain_rob();
		check_val("ret_free_tag_o", last_free, 0);
		report(5, "zero register", e0);

		e0 = errors;
		for (int c = 0; c < 300; c++) begin
			open.delete();
			foreach (m_q[i]) if (!m_q[i].done) open.push_back(i);
			k = (open.size() > 0 && $urandom % 2) ? open[$urandom % open.size()] : -1;
			run_cycle(($urandom % 4) != 0, LOG_W'($urandom), ($urandom % 4) == 0, $urandom % 2,
				k >= 0, (k >= 0) ? m_q[k].idx : '0, $urandom % 2, fired);
		end
		drain_rob();
		report(6, "random traffic", e0);

		$display("%0d tests, %0d checks, %0d errors", 6, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
